// ==== all.f ====
verilog/bexkat_isa_pkg.sv
verilog/bexkat_bus_pkg.sv
verilog/byte_lanes.sv
verilog/mem_stage.sv
verilog/data_ram.sv
verilog/writeback_stage.sv
verilog/mem_subsystem_top.sv
verif/clock_gen.sv
verif/tb_mem_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator and run the memory subsystem testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_mem_subsystem -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_mem_subsystem)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
echo "pass message not found"
exit 1

// ==== verif/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0; // release on a rising edge
  end

endmodule

// ==== verif/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;

  localparam int WAIT_STATES    = 2;
  localparam int RAM_WORDS      = 256;
  localparam int TIMEOUT_CYCLES = 40;
  localparam int RANDOM_COUNT   = 24;

  typedef struct packed {
    bexkat_isa_pkg::ir_type_e   ir_type;
    logic [3:0]                 op;
    logic [3:0]                 ra;
    logic [31:0]                adr;
    logic [31:0]                data;
    bexkat_isa_pkg::reg_write_e rw;
    logic                       halt;
    int                         hold;  // cycles of stall_i
    logic                       want_we;
    logic                       want_sp_we;
    logic                       want_halted;
    logic [31:0]                want_data;
  } entry_t;

  logic                       clk;
  logic                       rst;
  bexkat_isa_pkg::ir_fields_t ir_in;
  logic [31:0]                result_in;
  logic [31:0]                store_data;
  bexkat_isa_pkg::reg_write_e reg_write;
  logic                       halt;
  logic                       stall_in;
  logic                       stall_out;
  logic                       wb_we;
  logic                       wb_sp_we;
  logic [3:0]                 wb_reg;
  logic [31:0]                wb_data;
  logic                       halted;

  entry_t     stim_q[$];
  logic [7:0] ref_mem [RAM_WORDS*4]; // byte 0 of a word is its top byte
  bit         ref_ok [RAM_WORDS*4];
  bit         halted_model;

  clock_gen clk0 (
    .clk_o (clk),
    .rst_o (rst)
  );

  mem_subsystem_top #(
    .WAIT_STATES (WAIT_STATES),
    .RAM_WORDS   (RAM_WORDS)
  ) dut0 (
    .clk_i       (clk),
    .rst_i       (rst),
    .ir_i        (ir_in),
    .result_i    (result_in),
    .reg_data1_i (store_data),
    .reg_write_i (reg_write),
    .halt_i      (halt),
    .stall_i     (stall_in),
    .stall_o     (stall_out),
    .wb_we_o     (wb_we),
    .wb_sp_we_o  (wb_sp_we),
    .wb_reg_o    (wb_reg),
    .wb_data_o   (wb_data),
    .halted_o    (halted)
  );

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("error: %s = %0h, expected %0h", name, got, want);
    $display("TEST FAIL");
    $fatal(1, "check on %s", name);
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "run stopped");
  endtask

  function automatic int access_bytes(input logic [3:0] op);
    case (op[1:0])
      2'd1:    return 2;
      2'd2:    return 1;
      default: return 4; // op 0 and 3
    endcase
  endfunction

  // first byte touched, big-endian within the word
  function automatic int start_byte(input logic [31:0] adr, input int nbytes);
    int word;
    int off;
    word = int'({2'b00, adr[31:2]}) % RAM_WORDS;
    if (nbytes == 4)
      off = 0;
    else if (nbytes == 2)
      off = adr[1] ? 2 : 0;
    else
      off = int'({30'h0, adr[1:0]});
    return word * 4 + off;
  endfunction

  function automatic void ref_store(input logic [3:0] op, input logic [31:0] adr,
                                    input logic [31:0] data);
    int n;
    int s;
    n = access_bytes(op);
    s = start_byte(adr, n);
    for (int i = 0; i < n; i++)
    begin
      ref_mem[s + i] = data[8*(n-1-i) +: 8];
      ref_ok[s + i]  = 1'b1;
    end
  endfunction

  function automatic logic [31:0] ref_load(input logic [3:0] op, input logic [31:0] adr);
    int          n;
    int          s;
    logic [31:0] val;
    n   = access_bytes(op);
    s   = start_byte(adr, n);
    val = 32'h0;
    for (int i = 0; i < n; i++)
      val = {val[23:0], ref_mem[s + i]};
    return val;
  endfunction

  function automatic bit loadable(input logic [3:0] op, input logic [31:0] adr);
    int n;
    int s;
    n = access_bytes(op);
    s = start_byte(adr, n);
    for (int i = 0; i < n; i++)
      if (!ref_ok[s + i])
        return 1'b0;
    return 1'b1;
  endfunction

  function automatic void add_entry(input bexkat_isa_pkg::ir_type_e ty, input logic [3:0] op,
                                    input logic [3:0] ra, input logic [31:0] adr,
                                    input logic [31:0] data,
                                    input bexkat_isa_pkg::reg_write_e rw,
                                    input logic hlt, input int hold);
    entry_t e;
    e = '{ir_type: ty, op: op, ra: ra, adr: adr, data: data, rw: rw, halt: hlt,
          hold: hold, want_we: 1'b0, want_sp_we: 1'b0, want_halted: 1'b0,
          want_data: adr};
    if (ty == bexkat_isa_pkg::T_STORE)
      ref_store(op, adr, data);
    else if (ty == bexkat_isa_pkg::T_LOAD)
      e.want_data = ref_load(op, adr);
    if (hlt)
      halted_model = 1'b1;
    e.want_halted = halted_model;
    case (rw)
      bexkat_isa_pkg::RW_REG:  e.want_we = 1'b1;
      bexkat_isa_pkg::RW_SP:   e.want_sp_we = 1'b1;
      bexkat_isa_pkg::RW_BOTH:
      begin
        e.want_we    = 1'b1;
        e.want_sp_we = 1'b1;
      end
      default: e.want_we = 1'b0;
    endcase
    if (halted_model)
    begin
      e.want_we    = 1'b0;
      e.want_sp_we = 1'b0;
    end
    stim_q.push_back(e);
  endfunction

  function automatic void add_random_entries(input int count);
    logic [31:0]              r;
    logic [31:0]              adr;
    bexkat_isa_pkg::ir_type_e ty;
    for (int i = 0; i < count; i++)
    begin
      r   = $urandom;
      adr = $urandom & 32'hffff_f03f; // 16 words, high bits alias
      case (r[1:0])
        2'd0:    ty = bexkat_isa_pkg::T_ALU;
        2'd1:    ty = bexkat_isa_pkg::T_LOAD;
        2'd2:    ty = bexkat_isa_pkg::T_STORE;
        default: ty = bexkat_isa_pkg::T_MOV;
      endcase
      if (ty == bexkat_isa_pkg::T_LOAD && !loadable(r[7:4], adr))
        ty = bexkat_isa_pkg::T_STORE; // never read bytes not yet written
      add_entry(ty, r[7:4], r[11:8], adr, $urandom,
                bexkat_isa_pkg::reg_write_e'(r[13:12]), 1'b0, 0);
    end
  endfunction

  function automatic void build_table();
    add_entry(bexkat_isa_pkg::T_ALU, 4'h0, 4'h3, 32'h1234_5678, 32'h0,
              bexkat_isa_pkg::RW_REG, 1'b0, 0);
    // word store then load
    add_entry(bexkat_isa_pkg::T_STORE, 4'h0, 4'h0, 32'h40, 32'ha1b2_c3d4,
              bexkat_isa_pkg::RW_NONE, 1'b0, 0);
    add_entry(bexkat_isa_pkg::T_LOAD, 4'h0, 4'h5, 32'h40, 32'h0,
              bexkat_isa_pkg::RW_REG, 1'b0, 0);
    add_entry(bexkat_isa_pkg::T_LOAD, 4'h3, 4'h6, 32'h42, 32'h0,
              bexkat_isa_pkg::RW_REG, 1'b0, 0);
    // halfwords
    add_entry(bexkat_isa_pkg::T_STORE, 4'h1, 4'h0, 32'h44, 32'h1111_beef,
              bexkat_isa_pkg::RW_NONE, 1'b0, 0);
    add_entry(bexkat_isa_pkg::T_STORE, 4'h1, 4'h0, 32'h46, 32'h2222_cafe,
              bexkat_isa_pkg::RW_NONE, 1'b0, 0);
    add_entry(bexkat_isa_pkg::T_LOAD, 4'h0, 4'h1, 32'h44, 32'h0,
              bexkat_isa_pkg::RW_REG, 1'b0, 0);
    add_entry(bexkat_isa_pkg::T_LOAD, 4'h1, 4'h2, 32'h44, 32'h0,
              bexkat_isa_pkg::RW_REG, 1'b0, 0);
    add_entry(bexkat_isa_pkg::T_LOAD, 4'h1, 4'h2, 32'h47, 32'h0,
              bexkat_isa_pkg::RW_REG, 1'b0, 0);
    // one byte per offset
    for (int b = 0; b < 4; b++)
      add_entry(bexkat_isa_pkg::T_STORE, 4'h2, 4'h0, 32'h48 + 32'(b), 32'(8'h11 * (b + 1)),
                bexkat_isa_pkg::RW_NONE, 1'b0, 0);
    add_entry(bexkat_isa_pkg::T_LOAD, 4'h0, 4'h4, 32'h48, 32'h0,
              bexkat_isa_pkg::RW_REG, 1'b0, 0);
    for (int b = 0; b < 4; b++)
      add_entry(bexkat_isa_pkg::T_LOAD, 4'h2, 4'h8, 32'h48 + 32'(b), 32'h0,
                bexkat_isa_pkg::RW_REG, 1'b0, 0);
    add_entry(bexkat_isa_pkg::T_ALU, 4'h0, 4'h9, 32'h5555_0001, 32'h0,
              bexkat_isa_pkg::RW_REG, 1'b0, 3);
    add_entry(bexkat_isa_pkg::T_MOV, 4'h0, 4'hf, 32'h0000_fff0, 32'h0,
              bexkat_isa_pkg::RW_SP, 1'b0, 0);
    add_entry(bexkat_isa_pkg::T_POP, 4'h0, 4'ha, 32'h0000_1234, 32'h0,
              bexkat_isa_pkg::RW_BOTH, 1'b0, 0);
    add_random_entries(RANDOM_COUNT);
    // halt, then nothing may write
    add_entry(bexkat_isa_pkg::T_ALU, 4'h0, 4'h7, 32'h0bad_0001, 32'h0,
              bexkat_isa_pkg::RW_REG, 1'b1, 0);
    add_entry(bexkat_isa_pkg::T_LOAD, 4'h0, 4'h5, 32'h40, 32'h0,
              bexkat_isa_pkg::RW_BOTH, 1'b0, 0);
    add_entry(bexkat_isa_pkg::T_MOV, 4'h0, 4'h2, 32'h0000_00aa, 32'h0,
              bexkat_isa_pkg::RW_SP, 1'b0, 0);
  endfunction

  task automatic run_entry(input entry_t e);
    bexkat_isa_pkg::ir_fields_t ir;
    logic [38:0]                snap;
    int                         stalls;
    int                         want_stalls;
    ir         = '0;
    ir.ir_type = e.ir_type;
    ir.op      = e.op;
    ir.ra      = e.ra;
    stalls     = 0;
    want_stalls = (e.ir_type == bexkat_isa_pkg::T_LOAD ||
                   e.ir_type == bexkat_isa_pkg::T_STORE) ? WAIT_STATES : 0;
    @(posedge clk);
    ir_in      <= ir;
    result_in  <= e.adr;
    store_data <= e.data;
    reg_write  <= e.rw;
    halt       <= e.halt;
    @(negedge clk);
    while (stall_out)
    begin
      stalls++;
      if (stalls > TIMEOUT_CYCLES)
        report_problem("stall_o never dropped, the RAM did not answer");
      @(negedge clk);
    end
    @(posedge clk); // capture edge, feed a bubble behind the entry
    ir_in      <= '0;
    result_in  <= 32'h0;
    store_data <= 32'h0;
    reg_write  <= bexkat_isa_pkg::RW_NONE;
    halt       <= 1'b0;
    stall_in   <= (e.hold != 0); // entry sits in mem stage, bubble in writeback
    if (e.hold != 0)
    begin
      @(negedge clk);
      snap = {halted, wb_sp_we, wb_we, wb_reg, wb_data};
      for (int i = 0; i < e.hold; i++)
      begin
        @(negedge clk);
        hold_stable: assert ({halted, wb_sp_we, wb_we, wb_reg, wb_data} == snap)
          else report_mismatch("writeback outputs under stall_i",
                               64'({halted, wb_sp_we, wb_we, wb_reg, wb_data}), 64'(snap));
      end
      @(posedge clk);
      stall_in <= 1'b0;
    end
    @(posedge clk);
    @(negedge clk);
    stall_len: assert (stalls == want_stalls)
      else report_mismatch("stall_o cycles", 64'(stalls), 64'(want_stalls));
    we_ok: assert (wb_we == e.want_we)
      else report_mismatch("wb_we_o", 64'(wb_we), 64'(e.want_we));
    sp_we_ok: assert (wb_sp_we == e.want_sp_we)
      else report_mismatch("wb_sp_we_o", 64'(wb_sp_we), 64'(e.want_sp_we));
    reg_ok: assert (wb_reg == e.ra)
      else report_mismatch("wb_reg_o", 64'(wb_reg), 64'(e.ra));
    data_ok: assert (wb_data == e.want_data)
      else report_mismatch("wb_data_o", 64'(wb_data), 64'(e.want_data));
    halted_ok: assert (halted == e.want_halted)
      else report_mismatch("halted_o", 64'(halted), 64'(e.want_halted));
  endtask

  initial
  begin
    int guard;
    void'($urandom(32'hc973));
    ir_in      = '0;
    result_in  = 32'h0;
    store_data = 32'h0;
    reg_write  = bexkat_isa_pkg::RW_NONE;
    halt       = 1'b0;
    stall_in   = 1'b0;
    build_table();
    guard = 0;
    @(negedge clk);
    while (rst)
    begin
      guard++;
      if (guard > TIMEOUT_CYCLES)
        report_problem("reset was never released");
      @(negedge clk);
    end
    reset_quiet: assert (!wb_we && !wb_sp_we && !halted && !stall_out)
      else report_mismatch("wb_we_o, wb_sp_we_o, halted_o, stall_o after reset",
                           64'({wb_we, wb_sp_we, halted, stall_out}), 64'h0);
    for (int k = 0; k < stim_q.size(); k++)
      run_entry(stim_q[k]);
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== verilog/bexkat_bus_pkg.sv ====
package bexkat_bus_pkg;

  typedef enum logic [1:0] {
    SZ_WORD = 2'h0,
    SZ_HALF = 2'h1,
    SZ_BYTE = 2'h2
  } acc_size_e;

  // request side of the data bus, cyc is a level
  typedef struct packed {
    logic        cyc;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel; // sel[3] is byte address 0
  } bus_req_t;

  // ack is a single-cycle strobe, dat valid with it
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } bus_rsp_t;

endpackage

// ==== verilog/bexkat_isa_pkg.sv ====
package bexkat_isa_pkg;

  // instruction class, top nibble of the low ir word
  typedef enum logic [3:0] {
    T_INH    = 4'h0,
    T_PUSH   = 4'h1,
    T_POP    = 4'h2,
    T_CMP    = 4'h3,
    T_MOV    = 4'h4,
    T_INTU   = 4'h5,
    T_INT    = 4'h6,
    T_FPU    = 4'h7,
    T_FP     = 4'h8,
    T_ALU    = 4'h9,
    T_LOAD   = 4'ha,
    T_STORE  = 4'hb,
    T_LDI    = 4'hc,
    T_JUMP   = 4'hd,
    T_BRANCH = 4'he,
    T_RSVD   = 4'hf
  } ir_type_e;

  // low op bits of a load or store give the access size
  localparam logic [1:0] OP_SZ_WORD  = 2'h0;
  localparam logic [1:0] OP_SZ_HALF  = 2'h1;
  localparam logic [1:0] OP_SZ_BYTE  = 2'h2;
  localparam logic [1:0] OP_SZ_WORD2 = 2'h3; // alternate word encoding

  // what the writeback stage is allowed to update
  typedef enum logic [1:0] {
    RW_NONE = 2'h0,
    RW_REG  = 2'h1,
    RW_SP   = 2'h2,
    RW_BOTH = 2'h3
  } reg_write_e;

  typedef struct packed {
    logic [31:0] imm;     // second instruction word
    ir_type_e    ir_type;
    logic [3:0]  op;
    logic [3:0]  ra;      // destination
    logic [3:0]  rb;
    logic [3:0]  rc;
    logic [11:0] rsvd;
  } ir_fields_t;

endpackage

// ==== verilog/byte_lanes.sv ====
`timescale 1ns/1ps

module byte_lanes (
  input  bexkat_bus_pkg::acc_size_e size_i,
  input  logic [1:0]                adr_lo_i,
  input  logic [31:0]               st_data_i,
  input  logic [31:0]               rd_data_i,
  output logic [3:0]                sel_o,
  output logic [31:0]               st_data_o,
  output logic [31:0]               ld_data_o
);

  logic [1:0] lane;

  assign lane = 2'd3 - adr_lo_i; // big-endian, byte 0 lives in lane 3

  always_comb
  begin
    case (size_i)
      bexkat_bus_pkg::SZ_HALF:
      begin
        sel_o     = adr_lo_i[1] ? 4'b0011 : 4'b1100;
        st_data_o = {2{st_data_i[15:0]}};
        if (adr_lo_i[1])
          ld_data_o = {16'h0, rd_data_i[15:0]};
        else
          ld_data_o = {16'h0, rd_data_i[31:16]};
      end
      bexkat_bus_pkg::SZ_BYTE:
      begin
        sel_o     = 4'b0001 << lane;
        st_data_o = {4{st_data_i[7:0]}};
        ld_data_o = {24'h0, rd_data_i[{lane, 3'b000} +: 8]};
      end
      default:
      begin
        sel_o     = 4'b1111; // word and unused encoding
        st_data_o = st_data_i;
        ld_data_o = rd_data_i;
      end
    endcase
  end

endmodule

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
  parameter int WAIT_STATES = 2,
  parameter int RAM_WORDS   = 256
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  bexkat_bus_pkg::bus_req_t req_i,
  output bexkat_bus_pkg::bus_rsp_t rsp_o
);

  localparam int CW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
  localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  logic [31:0]   mem [RAM_WORDS];
  logic [CW-1:0] wait_cnt;
  logic [AW-1:0] word_idx;
  logic          ack;

  assign word_idx = AW'(req_i.adr[31:2] % RAM_WORDS); // wraps on RAM size

  // ack in the cycle the count reaches the wait-state setting
  assign ack = req_i.cyc && (wait_cnt == CW'(WAIT_STATES));

  assign rsp_o.ack = ack;
  assign rsp_o.dat = mem[word_idx];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      wait_cnt <= '0;
    else if (ack || !req_i.cyc)
      wait_cnt <= '0;
    else
      wait_cnt <= wait_cnt + 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (ack && req_i.we)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (req_i.sel[i])
          mem[word_idx][8*i +: 8] <= req_i.dat[8*i +: 8];
      end
    end
  end

  // a fresh request is answered after exactly WAIT_STATES more cycles
  a_ack_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(req_i.cyc) |-> ##WAIT_STATES rsp_o.ack);

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       stall_i,
  input  logic                       halt_i,
  input  bexkat_isa_pkg::ir_fields_t ir_i,
  input  logic [31:0]                result_i,
  input  logic [31:0]                reg_data1_i,
  input  bexkat_isa_pkg::reg_write_e reg_write_i,
  input  bexkat_bus_pkg::bus_rsp_t   bus_rsp_i,
  output logic                       stall_o,
  output logic                       halt_o,
  output bexkat_isa_pkg::ir_fields_t ir_o,
  output logic [31:0]                result_o,
  output bexkat_isa_pkg::reg_write_e reg_write_o,
  output bexkat_bus_pkg::bus_req_t   bus_req_o
);

  logic                      is_load;
  logic                      is_store;
  logic                      hold;
  bexkat_bus_pkg::acc_size_e size;
  logic [3:0]                sel;
  logic [31:0]               st_data;
  logic [31:0]               ld_data;

  assign is_load  = (ir_i.ir_type == bexkat_isa_pkg::T_LOAD);
  assign is_store = (ir_i.ir_type == bexkat_isa_pkg::T_STORE);

  always_comb
  begin
    case (ir_i.op[1:0])
      bexkat_isa_pkg::OP_SZ_HALF: size = bexkat_bus_pkg::SZ_HALF;
      bexkat_isa_pkg::OP_SZ_BYTE: size = bexkat_bus_pkg::SZ_BYTE;
      default:                    size = bexkat_bus_pkg::SZ_WORD; // op 0 and 3
    endcase
  end

  byte_lanes lanes0 (
    .size_i    (size),
    .adr_lo_i  (result_i[1:0]),
    .st_data_i (reg_data1_i),
    .rd_data_i (bus_rsp_i.dat),
    .sel_o     (sel),
    .st_data_o (st_data),
    .ld_data_o (ld_data)
  );

  // request follows the instruction presented to the stage
  always_comb
  begin
    bus_req_o.cyc = is_load || is_store;
    bus_req_o.we  = is_store;
    bus_req_o.adr = result_i;
    bus_req_o.dat = st_data;
    bus_req_o.sel = sel;
  end

  assign stall_o = bus_req_o.cyc && !bus_rsp_i.ack;
  assign hold    = stall_i || stall_o;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      ir_o        <= '0;
      result_o    <= 32'h0;
      reg_write_o <= bexkat_isa_pkg::RW_NONE;
      halt_o      <= 1'b0;
    end
    else if (!hold)
    begin
      ir_o        <= ir_i;
      result_o    <= is_load ? ld_data : result_i; // load value replaces address
      reg_write_o <= reg_write_i;
      halt_o      <= halt_i;
    end
  end

  // upstream must hold the op until the RAM answers
  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_o |=> $stable(bus_req_o));

endmodule

// ==== verilog/mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top #(
  parameter int WAIT_STATES = 2,
  parameter int RAM_WORDS   = 256
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  bexkat_isa_pkg::ir_fields_t ir_i,
  input  logic [31:0]                result_i,
  input  logic [31:0]                reg_data1_i,
  input  bexkat_isa_pkg::reg_write_e reg_write_i,
  input  logic                       halt_i,
  input  logic                       stall_i,
  output logic                       stall_o,
  output logic                       wb_we_o,
  output logic                       wb_sp_we_o,
  output logic [3:0]                 wb_reg_o,
  output logic [31:0]                wb_data_o,
  output logic                       halted_o
);

  bexkat_bus_pkg::bus_req_t   bus_req;
  bexkat_bus_pkg::bus_rsp_t   bus_rsp;
  bexkat_isa_pkg::ir_fields_t mem_ir;
  bexkat_isa_pkg::reg_write_e mem_reg_write;
  logic [31:0]                mem_result;
  logic                       mem_halt;

  mem_stage mem0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .stall_i     (stall_i),
    .halt_i      (halt_i),
    .ir_i        (ir_i),
    .result_i    (result_i),
    .reg_data1_i (reg_data1_i),
    .reg_write_i (reg_write_i),
    .bus_rsp_i   (bus_rsp),
    .stall_o     (stall_o),
    .halt_o      (mem_halt),
    .ir_o        (mem_ir),
    .result_o    (mem_result),
    .reg_write_o (mem_reg_write),
    .bus_req_o   (bus_req)
  );

  data_ram #(
    .WAIT_STATES (WAIT_STATES),
    .RAM_WORDS   (RAM_WORDS)
  ) ram0 (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (bus_req),
    .rsp_o (bus_rsp)
  );

  // writeback only sees the downstream hold
  writeback_stage wb0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .stall_i     (stall_i),
    .halt_i      (mem_halt),
    .ir_i        (mem_ir),
    .result_i    (mem_result),
    .reg_write_i (mem_reg_write),
    .wb_we_o     (wb_we_o),
    .wb_sp_we_o  (wb_sp_we_o),
    .wb_reg_o    (wb_reg_o),
    .wb_data_o   (wb_data_o),
    .halted_o    (halted_o)
  );

endmodule

// ==== verilog/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       stall_i,
  input  logic                       halt_i,
  input  bexkat_isa_pkg::ir_fields_t ir_i,
  input  logic [31:0]                result_i,
  input  bexkat_isa_pkg::reg_write_e reg_write_i,
  output logic                       wb_we_o,
  output logic                       wb_sp_we_o,
  output logic [3:0]                 wb_reg_o,
  output logic [31:0]                wb_data_o,
  output logic                       halted_o
);

  logic [3:0]                 reg_q;
  logic [31:0]                data_q;
  bexkat_isa_pkg::reg_write_e rw_q;
  logic                       halted_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      reg_q    <= 4'h0;
      data_q   <= 32'h0;
      rw_q     <= bexkat_isa_pkg::RW_NONE;
      halted_q <= 1'b0;
    end
    else if (!stall_i)
    begin
      reg_q  <= ir_i.ra;
      data_q <= result_i;
      rw_q   <= reg_write_i;
      if (halt_i)
        halted_q <= 1'b1; // sticky until reset
    end
  end

  assign wb_we_o    = !halted_q && (rw_q == bexkat_isa_pkg::RW_REG ||
                                    rw_q == bexkat_isa_pkg::RW_BOTH);
  assign wb_sp_we_o = !halted_q && (rw_q == bexkat_isa_pkg::RW_SP ||
                                    rw_q == bexkat_isa_pkg::RW_BOTH);
  assign wb_reg_o   = reg_q;
  assign wb_data_o  = data_q;
  assign halted_o   = halted_q;

endmodule
